// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module tb_auto_mode_controller -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: amc_pkg.sv
package amc_pkg;

    // Receiver and IMU word widths
    localparam int THROTTLE_W = 8;
    localparam int RATE_W     = 16;

    typedef logic        [THROTTLE_W-1:0] throttle_t;  // Unsigned receiver throttle
    typedef logic signed [RATE_W-1:0]     rate_t;      // Signed vertical velocity

    // Command sequencer states, one-hot
    typedef enum logic [4:0] {
        SEQ_INIT     = 5'b00001,  // Waiting for the IMU
        SEQ_WAIT     = 5'b00010,
        SEQ_LATCH    = 5'b00100,  // Pilot inputs sampled here
        SEQ_STEP     = 5'b01000,  // One flight-mode step
        SEQ_COMPLETE = 5'b10000
    } seq_state_t;

    // Flight modes, one-hot
    typedef enum logic [8:0] {
        FM_FAILSAFE      = 9'b0_0000_0001,
        FM_ON_GROUND     = 9'b0_0000_0010,
        FM_GND_THROT_OFF = 9'b0_0000_0100,
        FM_UP_START      = 9'b0_0000_1000,
        FM_DOWN_START    = 9'b0_0001_0000,
        FM_GO_UP         = 9'b0_0010_0000,
        FM_GO_DOWN       = 9'b0_0100_0000,
        FM_IN_AIR        = 9'b0_1000_0000,
        FM_NOT_AUTO      = 9'b1_0000_0000   // Manual pass-through
    } flight_mode_t;

    // Bit positions in the pilot switch words
    localparam int SWITCH_A_AUTO = 0;
    localparam int SWITCH_B_UP   = 0;
    localparam int SWITCH_B_DOWN = 1;

    // Input judgement limits
    localparam throttle_t THROTTLE_OFF_LIMIT = 8'd10;
    localparam rate_t     STILL_LIMIT        = 16'sd10;

    // Throttle set points per flight mode
    localparam throttle_t THR_GROUND  = 8'd15;
    localparam throttle_t THR_CLIMB   = 8'd25;
    localparam throttle_t THR_DESCEND = 8'd20;
    localparam throttle_t THR_HOVER   = 8'd30;

endpackage

// File: auto_mode_controller.sv
`timescale 1ns/1ps

module auto_mode_controller #(
    parameter int MOVE_TICKS = 10000  // Climb or descent length in us_clk cycles
) (
    input  logic                  us_clk,
    input  logic                  resetn,
    input  logic                  imu_good,
    input  logic                  start_signal,
    input  amc_pkg::throttle_t    throttle_in,
    input  amc_pkg::rate_t        z_linear_velocity,
    input  logic [2:0]            switch_a,
    input  logic [1:0]            switch_b,
    output amc_pkg::throttle_t    throttle_out,
    output amc_pkg::flight_mode_t flight_mode,
    output logic                  active_signal,
    output logic                  complete_signal
);

    import amc_pkg::*;

    logic       sample_en;
    logic       step_en;
    logic       imu_wait;
    throttle_t  throttle_s;
    logic [2:0] switch_a_s;
    logic [1:0] switch_b_s;
    logic       throttle_off;
    logic       still;

    cmd_sequencer cmd_sequencer_inst (
        .us_clk          (us_clk),
        .resetn          (resetn),
        .imu_good        (imu_good),
        .start_signal    (start_signal),
        .sample_en       (sample_en),
        .step_en         (step_en),
        .imu_wait        (imu_wait),
        .active_signal   (active_signal),
        .complete_signal (complete_signal)
    );

    pilot_sample_reg pilot_sample_reg_inst (
        .us_clk            (us_clk),
        .resetn            (resetn),
        .sample_en         (sample_en),
        .throttle_in       (throttle_in),
        .z_linear_velocity (z_linear_velocity),
        .switch_a          (switch_a),
        .switch_b          (switch_b),
        .throttle_s        (throttle_s),
        .switch_a_s        (switch_a_s),
        .switch_b_s        (switch_b_s),
        .throttle_off      (throttle_off),
        .still             (still)
    );

    flight_mode_fsm #(
        .MOVE_TICKS (MOVE_TICKS)
    ) flight_mode_fsm_inst (
        .us_clk       (us_clk),
        .resetn       (resetn),
        .step_en      (step_en),
        .imu_wait     (imu_wait),
        .throttle_s   (throttle_s),
        .switch_a_s   (switch_a_s),
        .switch_b_s   (switch_b_s),
        .throttle_off (throttle_off),
        .still        (still),
        .throttle_out (throttle_out),
        .flight_mode  (flight_mode)
    );

endmodule

// File: cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer (
    input  logic us_clk,
    input  logic resetn,
    input  logic imu_good,
    input  logic start_signal,
    output logic sample_en,
    output logic step_en,
    output logic imu_wait,
    output logic active_signal,
    output logic complete_signal
);

    import amc_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    logic       start_flag;

    // Start request capture
    // A new request wins over the clear, so one arriving mid-command is kept
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            start_flag <= 1'b0;
        end else if (start_signal) begin
            start_flag <= 1'b1;
        end else if (state == SEQ_LATCH) begin
            start_flag <= 1'b0;
        end
    end

    always_comb begin
        case (state)
            SEQ_INIT:     next_state = imu_good ? SEQ_WAIT : SEQ_INIT;
            SEQ_WAIT:     next_state = start_flag ? SEQ_LATCH : SEQ_WAIT;
            SEQ_LATCH:    next_state = SEQ_STEP;
            SEQ_STEP:     next_state = SEQ_COMPLETE;
            SEQ_COMPLETE: next_state = SEQ_WAIT;
            default:      next_state = SEQ_INIT;
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            state           <= SEQ_INIT;
            active_signal   <= 1'b0;
            complete_signal <= 1'b0;
        end else begin
            state           <= next_state;
            // Busy from the sample edge until the completion edge
            active_signal   <= (state == SEQ_LATCH) || (state == SEQ_STEP);
            complete_signal <= (state == SEQ_COMPLETE);  // One-cycle pulse
        end
    end

    assign sample_en = (state == SEQ_LATCH);
    assign step_en   = (state == SEQ_STEP);
    assign imu_wait  = (state == SEQ_INIT);  // Holds throttle at zero downstream

    a_state_onehot: assert property (
        @(posedge us_clk) disable iff (!resetn)
        $onehot(state)
    );

    a_active_complete_excl: assert property (
        @(posedge us_clk) disable iff (!resetn)
        !(active_signal && complete_signal)
    );

endmodule

// File: flight_mode_fsm.sv
`timescale 1ns/1ps

module flight_mode_fsm #(
    parameter int MOVE_TICKS = 10000
) (
    input  logic                  us_clk,
    input  logic                  resetn,
    input  logic                  step_en,
    input  logic                  imu_wait,
    input  amc_pkg::throttle_t    throttle_s,
    input  logic [2:0]            switch_a_s,
    input  logic [1:0]            switch_b_s,
    input  logic                  throttle_off,
    input  logic                  still,
    output amc_pkg::throttle_t    throttle_out,
    output amc_pkg::flight_mode_t flight_mode
);

    import amc_pkg::*;

    localparam int CNT_W = $clog2(MOVE_TICKS + 1);

    flight_mode_t     next_mode;
    throttle_t        next_throttle;
    logic             auto_on;
    logic             up_sel;
    logic             down_sel;
    logic             guarded;
    logic             timer_load;
    logic             timer_expired;
    logic [CNT_W-1:0] move_cnt;

    assign auto_on  = switch_a_s[SWITCH_A_AUTO];
    assign up_sel   = switch_b_s[SWITCH_B_UP];
    assign down_sel = switch_b_s[SWITCH_B_DOWN];

    // Start modes and manual pass-through skip the failsafe and auto checks
    assign guarded = (flight_mode != FM_NOT_AUTO) &&
                     (flight_mode != FM_UP_START) &&
                     (flight_mode != FM_DOWN_START);

    always_comb begin
        next_mode = flight_mode;
        if (guarded && throttle_off) begin
            next_mode = FM_FAILSAFE;
        end else if (guarded && !auto_on) begin
            next_mode = FM_NOT_AUTO;
        end else begin
            case (flight_mode)
                FM_FAILSAFE: next_mode = FM_ON_GROUND;  // Throttle is back on
                FM_ON_GROUND: begin
                    if (up_sel) begin
                        next_mode = FM_UP_START;
                    end else if (still) begin
                        next_mode = FM_GND_THROT_OFF;
                    end
                end
                FM_UP_START:   next_mode = FM_GO_UP;
                FM_DOWN_START: next_mode = FM_GO_DOWN;
                FM_GO_UP: begin
                    if (timer_expired) begin
                        next_mode = FM_IN_AIR;
                    end
                end
                FM_GO_DOWN: begin
                    if (timer_expired) begin
                        next_mode = FM_ON_GROUND;
                    end
                end
                FM_IN_AIR: begin
                    if (down_sel) begin
                        next_mode = FM_DOWN_START;
                    end
                end
                FM_NOT_AUTO: begin
                    if (auto_on) begin
                        next_mode = FM_IN_AIR;
                    end
                end
                default: next_mode = flight_mode;  // GND_THROT_OFF stays
            endcase
        end
    end

    // Throttle for the mode being entered
    always_comb begin
        case (next_mode)
            FM_FAILSAFE,
            FM_GND_THROT_OFF: next_throttle = '0;
            FM_ON_GROUND:     next_throttle = THR_GROUND;
            FM_GO_UP:         next_throttle = THR_CLIMB;
            FM_GO_DOWN:       next_throttle = THR_DESCEND;
            FM_IN_AIR:        next_throttle = THR_HOVER;
            FM_NOT_AUTO:      next_throttle = throttle_s;   // Pilot has direct control
            default:          next_throttle = throttle_out; // Start modes hold
        endcase
    end

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            flight_mode  <= FM_FAILSAFE;
            throttle_out <= '0;
        end else begin
            if (step_en) begin
                flight_mode <= next_mode;
            end
            if (imu_wait) begin
                throttle_out <= '0;
            end else if (step_en) begin
                throttle_out <= next_throttle;
            end
        end
    end

    // Move timer, armed on entry to a start mode
    assign timer_load    = step_en &&
                           ((next_mode == FM_UP_START) || (next_mode == FM_DOWN_START));
    assign timer_expired = (move_cnt == '0);

    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            move_cnt <= '0;
        end else if (timer_load) begin
            move_cnt <= CNT_W'(MOVE_TICKS);
        end else if (!timer_expired) begin
            move_cnt <= move_cnt - CNT_W'(1);  // Stops at zero
        end
    end

    a_failsafe_zero_throttle: assert property (
        @(posedge us_clk) disable iff (!resetn)
        (flight_mode == FM_FAILSAFE) |-> (throttle_out == '0)
    );

endmodule

// File: pilot_sample_reg.sv
`timescale 1ns/1ps

module pilot_sample_reg (
    input  logic                us_clk,
    input  logic                resetn,
    input  logic                sample_en,
    input  amc_pkg::throttle_t  throttle_in,
    input  amc_pkg::rate_t      z_linear_velocity,
    input  logic [2:0]          switch_a,
    input  logic [1:0]          switch_b,
    output amc_pkg::throttle_t  throttle_s,
    output logic [2:0]          switch_a_s,
    output logic [1:0]          switch_b_s,
    output logic                throttle_off,
    output logic                still
);

    import amc_pkg::*;

    logic throttle_off_d;
    logic still_d;

    // Judgements are made on the live inputs so they land on the same edge
    // as the sampled words
    assign throttle_off_d = (throttle_in < THROTTLE_OFF_LIMIT);
    assign still_d        = (z_linear_velocity > -STILL_LIMIT) &&
                            (z_linear_velocity < STILL_LIMIT);

    // Pilot words
    always_ff @(posedge us_clk) begin
        if (sample_en) begin
            throttle_s <= throttle_in;
            switch_a_s <= switch_a;
            switch_b_s <= switch_b;
        end
    end

    // Flags, throttle treated as off until the first sample
    always_ff @(posedge us_clk or negedge resetn) begin
        if (!resetn) begin
            throttle_off <= 1'b1;
            still        <= 1'b0;
        end else if (sample_en) begin
            throttle_off <= throttle_off_d;
            still        <= still_d;  // Strictly inside the band
        end
    end

endmodule

// File: sim.f
+incdir+.
amc_pkg.sv
cmd_sequencer.sv
pilot_sample_reg.sv
flight_mode_fsm.sv
auto_mode_controller.sv
tb_auto_mode_controller.sv

// File: tb_flight_model.svh
`ifndef TB_FLIGHT_MODEL_SVH
`define TB_FLIGHT_MODEL_SVH

// Next mode and throttle for one step, packed as {mode, throttle}
function automatic logic [16:0] model_step(
    input flight_mode_t mode,
    input throttle_t    last_thr,
    input throttle_t    thr,
    input rate_t        vel,
    input logic [2:0]   sa,
    input logic [1:0]   sb,
    input logic         expired
);
    logic         off;
    logic         stl;
    logic         checked;
    flight_mode_t nm;
    throttle_t    nt;
    off     = (thr < 8'd10);
    stl     = (vel > -16'sd10) && (vel < 16'sd10);  // Strictly inside the band
    checked = !((mode == FM_NOT_AUTO) || (mode == FM_UP_START) || (mode == FM_DOWN_START));
    nm      = mode;
    if (checked && off) begin
        nm = FM_FAILSAFE;
    end else if (checked && !sa[0]) begin
        nm = FM_NOT_AUTO;
    end else if (mode == FM_FAILSAFE) begin
        nm = FM_ON_GROUND;
    end else if (mode == FM_ON_GROUND) begin
        if (sb[0]) begin
            nm = FM_UP_START;
        end else if (stl) begin
            nm = FM_GND_THROT_OFF;
        end
    end else if (mode == FM_UP_START) begin
        nm = FM_GO_UP;
    end else if (mode == FM_DOWN_START) begin
        nm = FM_GO_DOWN;
    end else if (mode == FM_GO_UP && expired) begin
        nm = FM_IN_AIR;
    end else if (mode == FM_GO_DOWN && expired) begin
        nm = FM_ON_GROUND;
    end else if (mode == FM_IN_AIR && sb[1]) begin
        nm = FM_DOWN_START;
    end else if (mode == FM_NOT_AUTO && sa[0]) begin
        nm = FM_IN_AIR;
    end
    case (nm)
        FM_ON_GROUND: nt = 8'd15;
        FM_GO_UP:     nt = 8'd25;
        FM_GO_DOWN:   nt = 8'd20;
        FM_IN_AIR:    nt = 8'd30;
        FM_NOT_AUTO:  nt = thr;
        FM_UP_START,
        FM_DOWN_START: nt = last_thr;  // Held through the start modes
        default:      nt = 8'd0;
    endcase
    return {nm, nt};
endfunction

// Galois LFSR, one step per bit taken, bits collected LSB first
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
        val[i]    = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return val;
endfunction

task automatic check_throttle(input throttle_t got, input throttle_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error throttle_out got %h expected %h", got, exp);
    end
endtask

task automatic check_mode(input flight_mode_t got, input flight_mode_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error flight_mode got %h expected %h", got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("error %s got %h expected %h", name, got, exp);
    end
endtask

`endif

// File: tb_auto_mode_controller.sv
`timescale 1ns/1ps

module tb_auto_mode_controller;

    import amc_pkg::*;

    localparam int CMD_COUNT   = 100;  // Commands over all tests
    localparam int RESET_CYC   = 16;
    localparam int CYCLE_LIMIT = CMD_COUNT * 200 + RESET_CYC;

    logic         us_clk;
    logic         resetn;
    logic         imu_good;
    logic         start_signal;
    throttle_t    throttle_in;
    rate_t        z_linear_velocity;
    logic [2:0]   switch_a;
    logic [1:0]   switch_b;
    throttle_t    throttle_out;
    flight_mode_t flight_mode;
    logic         active_signal;
    logic         complete_signal;

    logic [31:0]  lfsr_state = 32'h6757_62a0;
    int           checks = 0;
    int           errors = 0;
    int           other_errors = 0;
    int           checks_done = 0;
    int           cycle_cnt = 0;
    int           test_num = 0;
    int           test_start_err;
    int           since_load = 0;
    logic         check_armed = 1'b0;
    logic         check_now = 1'b0;
    logic         active_prev = 1'b0;    // active_signal one cycle back
    flight_mode_t exp_mode;
    throttle_t    exp_thr;
    flight_mode_t mode_m = FM_FAILSAFE;  // Model state
    throttle_t    thr_m = 8'd0;
    logic         expired_m = 1'b1;      // Timer idles at zero after reset

    `include "tb_flight_model.svh"

    auto_mode_controller #(
        .MOVE_TICKS (40)
    ) auto_mode_controller_inst (
        .us_clk            (us_clk),
        .resetn            (resetn),
        .imu_good          (imu_good),
        .start_signal      (start_signal),
        .throttle_in       (throttle_in),
        .z_linear_velocity (z_linear_velocity),
        .switch_a          (switch_a),
        .switch_b          (switch_b),
        .throttle_out      (throttle_out),
        .flight_mode       (flight_mode),
        .active_signal     (active_signal),
        .complete_signal   (complete_signal)
    );

    always #50 us_clk = ~us_clk;

    // Compare process, on completion or on request
    always @(posedge us_clk) begin
        active_prev <= active_signal;
        if (check_armed && (complete_signal || check_now)) begin
            check_mode(flight_mode, exp_mode);
            check_throttle(throttle_out, exp_thr);
            check_flag("active_signal", active_signal, 1'b0);
            if (complete_signal) begin
                check_flag("active_signal", active_prev, 1'b1);  // Busy up to completion
            end
            checks_done <= checks_done + 1;
        end
    end

    always @(posedge us_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout, run exceeded %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic await_check();
        int target;
        target      = checks_done + 1;
        check_armed = 1'b1;
        wait (checks_done == target);
        check_armed = 1'b0;
        check_now   = 1'b0;
    endtask

    // Model the step, then drive one command
    task automatic run_cmd(input throttle_t thr, input rate_t vel, input logic [2:0] sa,
                           input logic [1:0] sb, input bit idle_first);
        logic [16:0] res;
        if (idle_first) begin
            repeat (100) @(posedge us_clk);
            expired_m = 1'b1;
        end
        res    = model_step(mode_m, thr_m, thr, vel, sa, sb, expired_m);
        mode_m = flight_mode_t'(res[16:8]);
        thr_m  = res[7:0];
        if (mode_m == FM_UP_START || mode_m == FM_DOWN_START) begin
            expired_m  = 1'b0;
            since_load = 0;
        end else begin
            since_load++;
        end
        exp_mode = mode_m;
        exp_thr  = thr_m;
        @(posedge us_clk);
        throttle_in       <= thr;
        z_linear_velocity <= vel;
        switch_a          <= sa;
        switch_b          <= sb;
        start_signal      <= 1'b1;
        @(posedge us_clk);
        start_signal <= 1'b0;
        await_check();
    endtask

    task automatic begin_test();
        test_num++;
        test_start_err = errors + other_errors;
    endtask

    task automatic end_test(input string name);
        if (errors + other_errors == test_start_err) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: failed", test_num, name);
        end
    endtask

    initial begin
        logic [16:0] res;
        logic [31:0] r;
        bit          seen;
        bit          idle;
        int          iv;
        throttle_t   thr;
        logic [2:0]  sa;
        us_clk            = 1'b0;
        resetn            = 1'b0;
        imu_good          = 1'b0;
        start_signal      = 1'b0;
        throttle_in       = '0;
        z_linear_velocity = '0;
        switch_a          = '0;
        switch_b          = '0;
        repeat (RESET_CYC) @(posedge us_clk);
        resetn <= 1'b1;

        begin_test();
        exp_mode  = FM_FAILSAFE;
        exp_thr   = 8'd0;
        check_now = 1'b1;
        await_check();
        @(posedge us_clk);
        start_signal <= 1'b1;
        @(posedge us_clk);
        start_signal <= 1'b0;
        seen = 1'b0;
        repeat (50) begin
            @(posedge us_clk);
            if (complete_signal) seen = 1'b1;
        end
        if (seen) begin
            other_errors++;
            $display("a command completed while imu_good was low");
        end
        // The held start request runs once the IMU is good
        res    = model_step(mode_m, thr_m, 8'd0, 16'sd0, 3'b000, 2'b00, expired_m);
        mode_m = flight_mode_t'(res[16:8]);
        thr_m  = res[7:0];
        exp_mode = mode_m;
        exp_thr  = thr_m;
        imu_good <= 1'b1;
        await_check();
        end_test("imu wait");

        begin_test();
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b01, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);  // Timer still running
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 1);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b10, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 1);
        end_test("full flight");

        begin_test();
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b01, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd5, 16'sd100, 3'b001, 2'b00, 0);  // Off while climbing
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b01, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 1);
        run_cmd(8'd3, 16'sd100, 3'b001, 2'b00, 0);  // Off while hovering
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b01, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 1);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b10, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd7, 16'sd100, 3'b001, 2'b00, 0);  // Off while descending
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        end_test("throttle failsafe");

        begin_test();
        run_cmd(8'd77, 16'sd100, 3'b000, 2'b00, 0);
        run_cmd(8'd120, 16'sd100, 3'b110, 2'b00, 0);
        run_cmd(8'd120, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b10, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 1);
        end_test("manual pass-through");

        begin_test();
        run_cmd(8'd50, 16'sd10, 3'b001, 2'b00, 0);   // Edge of the band, not still
        run_cmd(8'd50, -16'sd9, 3'b001, 2'b00, 0);
        run_cmd(8'd50, -16'sd9, 3'b001, 2'b01, 0);   // Stays put
        run_cmd(8'd0, 16'sd0, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd100, 3'b001, 2'b00, 0);
        run_cmd(8'd50, 16'sd9, 3'b001, 2'b00, 0);
        run_cmd(8'd0, 16'sd0, 3'b001, 2'b00, 0);
        run_cmd(8'd50, -16'sd10, 3'b001, 2'b00, 0);
        run_cmd(8'd50, -16'sd10, 3'b001, 2'b00, 0);
        end_test("still on ground");

        begin_test();
        for (int i = 0; i < 60; i++) begin
            r = rand_bits(2);
            if (r[1:0] == 2'b00) begin
                r   = rand_bits(4);
                thr = {4'b0, r[3:0]};
            end else begin
                r   = rand_bits(8);
                thr = r[7:0];
            end
            r  = rand_bits(5);
            iv = int'(r[4:0]) - 16;
            r  = rand_bits(3);
            sa = r[2:0];
            r  = rand_bits(2);
            if (r[1:0] != 2'b00) sa[0] = 1'b1;  // Mostly in auto
            r = rand_bits(1);
            idle = (mode_m == FM_GO_UP || mode_m == FM_GO_DOWN) &&
                   (since_load >= 3 || r[0]);
            r = rand_bits(2);
            run_cmd(thr, rate_t'(iv), sa, r[1:0], idle);
        end
        end_test("random commands");

        $display("tests %0d, checks %0d, errors %0d", test_num, checks,
                 errors + other_errors);
        if (errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
